/* hw/cpu_pkg.sv */
package cpu_pkg;

  localparam int DATA_W    = 32;
  localparam int IR_W      = 64;
  localparam int REG_N     = 16;
  localparam int REG_AW    = 4;
  localparam int INT_DELAY = 4;
  localparam int DELAY_W   = $clog2(INT_DELAY + 1);

  // instruction word fields
  localparam int IR_FIELD_W  = 4;
  localparam int IR_TYPE_LSB = 28;
  localparam int IR_OP_LSB   = 24;
  localparam int IR_RA_LSB   = 20;
  localparam int IR_RB_LSB   = 16;
  localparam int IR_RC_LSB   = 12;
  localparam int IR_IMM_LSB  = 1;
  localparam int IR_IMM_W    = 15;
  localparam int IR_SIZE_BIT = 0;
  localparam int IR_EXT_LSB  = 32;

  localparam logic [IR_FIELD_W-1:0] OP_HALT = 4'h4; // T_INH op

  // condition code bits
  localparam int CCR_LTU = 2;
  localparam int CCR_LT  = 1;
  localparam int CCR_EQ  = 0;

  typedef enum logic [3:0] {
    T_INH    = 4'h0,
    T_CMP    = 4'h3,
    T_INT    = 4'h6,
    T_ALU    = 4'h7,
    T_LDI    = 4'ha,
    T_BRANCH = 4'hb,
    T_JUMP   = 4'hc
  } ir_type_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SHL, ALU_SHR, ALU_ASR
  } alu_func_t;

  typedef enum logic [2:0] {
    INT_MUL, INT_MULU, INT_DIV, INT_DIVU, INT_MOD, INT_MODU
  } int_func_t;

endpackage

/* hw/alu_comb.sv */
`timescale 1ns/1ps

module alu_comb (
  input  logic [cpu_pkg::DATA_W-1:0] in1_i,
  input  logic [cpu_pkg::DATA_W-1:0] in2_i,
  input  cpu_pkg::alu_func_t         func_i,
  output logic [cpu_pkg::DATA_W-1:0] out_o,
  output logic                       c_o,
  output logic                       z_o,
  output logic                       n_o,
  output logic                       v_o
);
  import cpu_pkg::*;

  logic [DATA_W:0] sum;
  logic [DATA_W:0] diff;
  logic [$clog2(DATA_W)-1:0] shamt;

  assign sum   = {1'b0, in1_i} + {1'b0, in2_i};
  assign diff  = {1'b0, in1_i} - {1'b0, in2_i}; // msb is borrow
  assign shamt = in2_i[$clog2(DATA_W)-1:0];

  always_comb
  begin
    c_o = 1'b0;
    v_o = 1'b0;
    case (func_i)
      ALU_ADD:
      begin
        out_o = sum[DATA_W-1:0];
        c_o   = sum[DATA_W];
        v_o   = (in1_i[DATA_W-1] == in2_i[DATA_W-1]) && (sum[DATA_W-1] != in1_i[DATA_W-1]);
      end
      ALU_SUB:
      begin
        out_o = diff[DATA_W-1:0];
        c_o   = diff[DATA_W];
        v_o   = (in1_i[DATA_W-1] != in2_i[DATA_W-1]) && (diff[DATA_W-1] != in1_i[DATA_W-1]);
      end
      ALU_AND: out_o = in1_i & in2_i;
      ALU_OR:  out_o = in1_i | in2_i;
      ALU_XOR: out_o = in1_i ^ in2_i;
      ALU_SHL: out_o = in1_i << shamt;
      ALU_SHR: out_o = in1_i >> shamt;
      default: out_o = $signed(in1_i) >>> shamt; // asr
    endcase
  end

  assign z_o = (out_o == '0);
  assign n_o = out_o[DATA_W-1];

endmodule

/* hw/int_calc.sv */
`timescale 1ns/1ps

module int_calc (
  input  logic [cpu_pkg::DATA_W-1:0] in1_i,
  input  logic [cpu_pkg::DATA_W-1:0] in2_i,
  input  cpu_pkg::int_func_t         func_i,
  output logic [cpu_pkg::DATA_W-1:0] out_o
);
  import cpu_pkg::*;

  logic signed [DATA_W-1:0] s1;
  logic signed [DATA_W-1:0] s2;
  logic                     zero_div;
  logic [DATA_W-1:0]        quot_s, quot_u;
  logic [DATA_W-1:0]        rem_s, rem_u;

  assign s1       = in1_i;
  assign s2       = in2_i;
  assign zero_div = (in2_i == '0);

  // x/0 gives all ones, x%0 gives x
  assign quot_s = zero_div ? '1 : $unsigned(s1 / s2);
  assign quot_u = zero_div ? '1 : in1_i / in2_i;
  assign rem_s  = zero_div ? in1_i : $unsigned(s1 % s2);
  assign rem_u  = zero_div ? in1_i : in1_i % in2_i;

  always_comb
  begin
    case (func_i)
      INT_MUL, INT_MULU: out_o = in1_i * in2_i; // low half is sign independent
      INT_DIV:  out_o = quot_s;
      INT_DIVU: out_o = quot_u;
      INT_MOD:  out_o = rem_s;
      INT_MODU: out_o = rem_u;
      default:  out_o = '0;
    endcase
  end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [cpu_pkg::REG_AW-1:0] rd_addr1_i,
  input  logic [cpu_pkg::REG_AW-1:0] rd_addr2_i,
  input  logic [cpu_pkg::REG_AW-1:0] wr_addr_i,
  input  logic                       wr_en_i,
  input  logic [cpu_pkg::DATA_W-1:0] wr_data_i,
  output logic [cpu_pkg::DATA_W-1:0] rd_data1_o,
  output logic [cpu_pkg::DATA_W-1:0] rd_data2_o
);
  import cpu_pkg::*;

  logic [DATA_W-1:0] regs [REG_N];

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < REG_N; i++)
        regs[i] <= '0;
    end
    else if (wr_en_i)
      regs[wr_addr_i] <= wr_data_i;
  end

  // same-edge write shows up on the read port
  assign rd_data1_o = (wr_en_i && wr_addr_i == rd_addr1_i) ? wr_data_i : regs[rd_addr1_i];
  assign rd_data2_o = (wr_en_i && wr_addr_i == rd_addr2_i) ? wr_data_i : regs[rd_addr2_i];

  a_wr_addr_known: assert property (@(posedge clk_i) disable iff (rst_i)
    wr_en_i |-> !$isunknown(wr_addr_i));

endmodule

/* hw/operand_read.sv */
`timescale 1ns/1ps

module operand_read (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       issue_i,
  input  logic                       stall_i,
  input  logic [cpu_pkg::IR_W-1:0]   ir_i,
  input  logic [cpu_pkg::DATA_W-1:0] pc_i,
  input  logic [cpu_pkg::DATA_W-1:0] data1_i,
  input  logic [cpu_pkg::DATA_W-1:0] data2_i,
  output logic                       valid_o,
  output logic [cpu_pkg::IR_W-1:0]   ir_o,
  output logic [cpu_pkg::DATA_W-1:0] pc_o,
  output logic [cpu_pkg::DATA_W-1:0] data1_o,
  output logic [cpu_pkg::DATA_W-1:0] data2_o
);
  import cpu_pkg::*;

  logic accept;

  assign accept = issue_i && !stall_i;

  // bubble when nothing issued, hold under stall
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      valid_o <= 1'b0;
    else if (!stall_i)
      valid_o <= issue_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      ir_o    <= ir_i;
      pc_o    <= pc_i;
      data1_o <= data1_i;
      data2_o <= data2_i;
    end
  end

  a_hold_ir: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_i |=> $stable(ir_o));

  // execute only stalls on an instruction it holds
  a_stall_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_i |-> valid_o);

endmodule

/* hw/execute.sv */
`timescale 1ns/1ps

module execute (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       valid_i,
  input  logic [cpu_pkg::IR_W-1:0]   ir_i,
  input  logic [cpu_pkg::DATA_W-1:0] pc_i,
  input  logic [cpu_pkg::DATA_W-1:0] data1_i,
  input  logic [cpu_pkg::DATA_W-1:0] data2_i,
  output logic                       stall_o,
  output logic                       wb_valid_o,
  output logic [cpu_pkg::REG_AW-1:0] wb_reg_o,
  output logic [cpu_pkg::DATA_W-1:0] wb_data_o,
  output logic [2:0]                 ccr_o,
  output logic                       pc_set_o,
  output logic [cpu_pkg::DATA_W-1:0] pc_o,
  output logic                       halt_o
);
  import cpu_pkg::*;

  ir_type_t                ir_type;
  logic [IR_FIELD_W-1:0]   ir_op;
  logic [REG_AW-1:0]       ir_ra, ir_rb, ir_rc;
  logic [DATA_W-1:0]       ir_sval, ir_uval, ir_soff, ir_ext;
  logic                    ir_size;
  logic [DATA_W-1:0]       op1, op2;
  alu_func_t               alu_func;
  int_func_t               int_func;
  logic [DATA_W-1:0]       alu_in1, alu_in2, alu_out;
  logic                    alu_c, alu_z, alu_n, alu_v;
  logic [DATA_W-1:0]       int_out, int_q;
  logic [DELAY_W-1:0]      delay_q;
  logic                    stall_start, exec_go, take_branch;
  logic                    wb_valid_d, pc_set_d, halt_d;
  logic [DATA_W-1:0]       wb_data_d, pc_d;
  logic [2:0]              ccr_d;

  assign ir_type = ir_type_t'(ir_i[IR_TYPE_LSB +: IR_FIELD_W]);
  assign ir_op   = ir_i[IR_OP_LSB +: IR_FIELD_W];
  assign ir_ra   = ir_i[IR_RA_LSB +: REG_AW];
  assign ir_rb   = ir_i[IR_RB_LSB +: REG_AW];
  assign ir_rc   = ir_i[IR_RC_LSB +: REG_AW];
  assign ir_size = ir_i[IR_SIZE_BIT];
  assign ir_ext  = ir_i[IR_EXT_LSB +: DATA_W];
  assign ir_uval = {{(DATA_W-IR_IMM_W){1'b0}}, ir_i[IR_IMM_LSB +: IR_IMM_W]};
  assign ir_sval = {{(DATA_W-IR_IMM_W){ir_i[IR_IMM_LSB+IR_IMM_W-1]}},
                    ir_i[IR_IMM_LSB +: IR_IMM_W]};
  assign ir_soff = {ir_sval[DATA_W-3:0], 2'b00}; // word scaled

  // last result not yet in the register file
  assign op1 = (wb_valid_o && wb_reg_o == ir_rb) ? wb_data_o : data1_i;
  assign op2 = (wb_valid_o && wb_reg_o == ir_rc) ? wb_data_o : data2_i;

  assign stall_start = valid_i && !halt_o && (ir_type == T_INT) && (delay_q == '0);
  assign stall_o     = stall_start || (delay_q > DELAY_W'(1));
  assign exec_go     = valid_i && !stall_o && !halt_o;
  assign int_func    = int_func_t'(ir_op[2:0]);

  always_comb
  begin
    alu_func = alu_func_t'(ir_op[2:0]);
    alu_in1  = op1;
    alu_in2  = op2;
    case (ir_type)
      T_ALU:
      begin
        if (ir_op[3])
          alu_in2 = ir_sval;
      end
      T_CMP:
        alu_func = ALU_SUB;
      T_BRANCH:
      begin
        alu_func = ALU_ADD;
        alu_in1  = ir_soff;
        alu_in2  = pc_i;
      end
      T_JUMP:
      begin
        alu_func = ALU_ADD;
        alu_in2  = ir_soff; // rb + offset
      end
      default:
      begin
      end
    endcase
  end

  always_comb
  begin
    case (ir_op)
      4'h0:    take_branch = 1'b1;
      4'h1:    take_branch = ccr_o[CCR_EQ];
      4'h2:    take_branch = !ccr_o[CCR_EQ];
      4'h3:    take_branch = !(ccr_o[CCR_LTU] || ccr_o[CCR_EQ]);
      4'h4:    take_branch = !(ccr_o[CCR_LT] || ccr_o[CCR_EQ]);
      4'h5:    take_branch = !ccr_o[CCR_LT];
      4'h6:    take_branch = ccr_o[CCR_LT] || ccr_o[CCR_EQ];
      4'h7:    take_branch = ccr_o[CCR_LT];
      4'h8:    take_branch = !ccr_o[CCR_LTU];
      4'h9:    take_branch = ccr_o[CCR_LTU];
      4'ha:    take_branch = ccr_o[CCR_LTU] || ccr_o[CCR_EQ];
      default: take_branch = 1'b0;
    endcase
  end

  always_comb
  begin
    wb_valid_d = 1'b0;
    wb_data_d  = alu_out;
    pc_set_d   = 1'b0;
    pc_d       = alu_out;
    ccr_d      = ccr_o;
    halt_d     = halt_o;
    if (exec_go)
    begin
      case (ir_type)
        T_ALU:
          wb_valid_d = 1'b1;
        T_INT:
        begin
          wb_valid_d = 1'b1;
          wb_data_d  = int_q;
        end
        T_LDI:
        begin
          wb_valid_d = 1'b1;
          wb_data_d  = ir_size ? ir_ext : ir_uval;
        end
        T_CMP:
        begin
          ccr_d[CCR_LTU] = alu_c;
          ccr_d[CCR_LT]  = alu_n ^ alu_v;
          ccr_d[CCR_EQ]  = alu_z;
        end
        T_BRANCH:
          pc_set_d = take_branch;
        T_JUMP:
        begin
          pc_set_d = 1'b1;
          if (ir_size)
            pc_d = ir_ext;
        end
        T_INH:
          halt_d = halt_o || (ir_op == OP_HALT);
        default:
        begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wb_valid_o <= 1'b0;
      pc_set_o   <= 1'b0;
      halt_o     <= 1'b0;
      ccr_o      <= '0;
      delay_q    <= '0;
    end
    else
    begin
      wb_valid_o <= wb_valid_d;
      pc_set_o   <= pc_set_d;
      halt_o     <= halt_d;
      ccr_o      <= ccr_d;
      if (stall_start)
        delay_q <= DELAY_W'(INT_DELAY);
      else if (delay_q != '0)
        delay_q <= delay_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (stall_start)
      int_q <= int_out; // operands still forwarded here
    if (exec_go)
    begin
      wb_reg_o  <= ir_ra;
      wb_data_o <= wb_data_d;
      pc_o      <= pc_d;
    end
  end

  alu_comb u_alu (
    .in1_i  (alu_in1),
    .in2_i  (alu_in2),
    .func_i (alu_func),
    .out_o  (alu_out),
    .c_o    (alu_c),
    .z_o    (alu_z),
    .n_o    (alu_n),
    .v_o    (alu_v)
  );

  int_calc u_int (
    .in1_i  (op1),
    .in2_i  (op2),
    .func_i (int_func),
    .out_o  (int_out)
  );

  a_wb_xor_branch: assert property (@(posedge clk_i) disable iff (rst_i)
    !(pc_set_o && wb_valid_o));

  a_quiet_after_halt: assert property (@(posedge clk_i) disable iff (rst_i)
    halt_o |=> !(wb_valid_o || pc_set_o));

endmodule

/* hw/exec_top.sv */
`timescale 1ns/1ps

module exec_top (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       issue_i,
  input  logic [cpu_pkg::IR_W-1:0]   ir_i,
  input  logic [cpu_pkg::DATA_W-1:0] pc_i,
  output logic                       stall_o,
  output logic                       wb_valid_o,
  output logic [cpu_pkg::REG_AW-1:0] wb_reg_o,
  output logic [cpu_pkg::DATA_W-1:0] wb_data_o,
  output logic [2:0]                 ccr_o,
  output logic                       pc_set_o,
  output logic [cpu_pkg::DATA_W-1:0] pc_o,
  output logic                       halt_o
);
  import cpu_pkg::*;

  logic [DATA_W-1:0] rd_data1, rd_data2;
  logic              ex_valid;
  logic [IR_W-1:0]   ex_ir;
  logic [DATA_W-1:0] ex_pc, ex_data1, ex_data2;

  reg_file u_reg_file (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rd_addr1_i (ir_i[IR_RB_LSB +: REG_AW]),
    .rd_addr2_i (ir_i[IR_RC_LSB +: REG_AW]),
    .wr_addr_i  (wb_reg_o),
    .wr_en_i    (wb_valid_o),
    .wr_data_i  (wb_data_o),
    .rd_data1_o (rd_data1),
    .rd_data2_o (rd_data2)
  );

  operand_read u_operand_read (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .issue_i (issue_i),
    .stall_i (stall_o),
    .ir_i    (ir_i),
    .pc_i    (pc_i),
    .data1_i (rd_data1),
    .data2_i (rd_data2),
    .valid_o (ex_valid),
    .ir_o    (ex_ir),
    .pc_o    (ex_pc),
    .data1_o (ex_data1),
    .data2_o (ex_data2)
  );

  execute u_execute (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .valid_i    (ex_valid),
    .ir_i       (ex_ir),
    .pc_i       (ex_pc),
    .data1_i    (ex_data1),
    .data2_i    (ex_data2),
    .stall_o    (stall_o),
    .wb_valid_o (wb_valid_o),
    .wb_reg_o   (wb_reg_o),
    .wb_data_o  (wb_data_o),
    .ccr_o      (ccr_o),
    .pc_set_o   (pc_set_o),
    .pc_o       (pc_o),
    .halt_o     (halt_o)
  );

endmodule

/* test/exec_tb.sv */
`timescale 1ns/1ps

module exec_tb;
  import cpu_pkg::*;

  localparam int N_INSTR         = 400;
  localparam int N_AFTER         = 4; // issued after the halt, must vanish
  localparam int CLK_PERIOD      = 20;
  localparam int WATCHDOG_CYCLES = (N_INSTR + N_AFTER + 8) * (INT_DELAY + 3) + 200;
  localparam logic [IR_W-1:0] HALT_IR = {32'h0, T_INH, OP_HALT, 24'h0};

  logic              clk_i, rst_i, issue_i;
  logic [IR_W-1:0]   ir_i;
  logic [DATA_W-1:0] pc_i;
  logic              stall_o, wb_valid_o, pc_set_o, halt_o;
  logic [REG_AW-1:0] wb_reg_o;
  logic [DATA_W-1:0] wb_data_o, pc_o;
  logic [2:0]        ccr_o;

  logic [31:0]       lfsr_q;
  logic [DATA_W-1:0] m_regs [REG_N];
  logic              m_ltu, m_lt, m_eq, m_halted;
  logic [DATA_W-1:0] next_pc;
  bit                ev_br_q [$];
  logic [REG_AW-1:0] ev_reg_q [$];
  logic [DATA_W-1:0] ev_val_q [$];
  int                wb_err = 0;
  int                br_err = 0;
  int                seq_err = 0;
  int                end_err = 0;
  int                ev_seen = 0;
  int                stall_run = 0;
  int                stall_runs = 0;
  int                m_int_n = 0;

  exec_top dut_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .issue_i    (issue_i),
    .ir_i       (ir_i),
    .pc_i       (pc_i),
    .stall_o    (stall_o),
    .wb_valid_o (wb_valid_o),
    .wb_reg_o   (wb_reg_o),
    .wb_data_o  (wb_data_o),
    .ccr_o      (ccr_o),
    .pc_set_o   (pc_set_o),
    .pc_o       (pc_o),
    .halt_o     (halt_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial
  begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("timeout: the run did not reach its end in %0d cycles", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // half the picks land in r0..r3
  function automatic logic [REG_AW-1:0] pick_reg();
    return take_bits(1) ? REG_AW'(take_bits(2)) : REG_AW'(take_bits(4));
  endfunction

  function automatic int pick_bubbles();
    if (take_bits(2) == 0)
      return 1 + int'(take_bits(1));
    return 0;
  endfunction

  function automatic logic [IR_W-1:0] make_instr();
    logic [2:0]        sel;
    logic [3:0]        op;
    logic [REG_AW-1:0] ra, rb, rc;
    logic [15:0]       low;
    logic [31:0]       ext;
    ir_type_t          t;
    sel = 3'(take_bits(3));
    op  = 4'(take_bits(4));
    ra  = pick_reg();
    rb  = pick_reg();
    rc  = pick_reg();
    low = 16'(take_bits(16));
    ext = take_bits(32);
    case (sel)
      3'd0, 3'd1: t = T_ALU;
      3'd3:       t = T_CMP;
      3'd4:       t = T_BRANCH;
      3'd5:       t = T_INT;
      3'd6:       t = T_JUMP;
      default:    t = T_LDI;
    endcase
    if (t == T_INT)
      op = {1'b0, (op[2:0] > 3'd5) ? op[2:0] - 3'd2 : op[2:0]};
    if (t == T_BRANCH && op > 4'd10)
      op = op - 4'd5;
    if (t == T_LDI && op[1:0] == 2'b00)
    begin
      rc  = '0;
      low = '0; // zeros feed divide by zero and equal compares
    end
    return {ext, t, op, ra, rb, rc, low[11:0]};
  endfunction

  function automatic logic [DATA_W-1:0] alu_ref(input logic [2:0] f,
                                                input logic [DATA_W-1:0] a, b);
    case (alu_func_t'(f))
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SHL: return a << b[4:0];
      ALU_SHR: return a >> b[4:0];
      default: return DATA_W'($signed(a) >>> b[4:0]);
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] int_ref(input logic [2:0] f,
                                                input logic [DATA_W-1:0] a, b);
    longint      sa, sb;
    logic [63:0] prod;
    sa   = longint'($signed(a));
    sb   = longint'($signed(b));
    prod = {32'h0, a} * {32'h0, b};
    case (int_func_t'(f))
      INT_MUL:  return DATA_W'(sa * sb);
      INT_MULU: return prod[DATA_W-1:0];
      INT_DIV:  return (b == '0) ? '1 : DATA_W'(sa / sb);
      INT_DIVU: return (b == '0) ? '1 : a / b;
      INT_MOD:  return (b == '0) ? a : DATA_W'(sa % sb);
      INT_MODU: return (b == '0) ? a : a % b;
      default:  return '0;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [3:0] op);
    case (op)
      4'd0:    return 1'b1;
      4'd1:    return m_eq;
      4'd2:    return !m_eq;
      4'd3:    return !m_ltu && !m_eq;
      4'd4:    return !m_lt && !m_eq;
      4'd5:    return !m_lt;
      4'd6:    return m_lt || m_eq;
      4'd7:    return m_lt;
      4'd8:    return !m_ltu;
      4'd9:    return m_ltu;
      4'd10:   return m_ltu || m_eq;
      default: return 1'b0;
    endcase
  endfunction

  task automatic push_event(input bit is_br, input logic [REG_AW-1:0] ra,
                            input logic [DATA_W-1:0] val);
    if (!is_br)
      m_regs[ra] = val;
    ev_br_q.push_back(is_br);
    ev_reg_q.push_back(ra);
    ev_val_q.push_back(val);
  endtask

  // in-order reference execution
  task automatic model_exec(input logic [IR_W-1:0] ir, input logic [DATA_W-1:0] pc);
    ir_type_t          t;
    logic [3:0]        op;
    logic [REG_AW-1:0] ra;
    logic [DATA_W-1:0] a, b, sval, soff, ext;
    t    = ir_type_t'(ir[IR_TYPE_LSB +: 4]);
    op   = ir[IR_OP_LSB +: 4];
    ra   = ir[IR_RA_LSB +: REG_AW];
    a    = m_regs[ir[IR_RB_LSB +: REG_AW]];
    b    = m_regs[ir[IR_RC_LSB +: REG_AW]];
    sval = {{17{ir[15]}}, ir[15:1]};
    soff = {sval[29:0], 2'b00};
    ext  = ir[IR_EXT_LSB +: DATA_W];
    if (!m_halted)
    begin
      case (t)
        T_ALU:    push_event(1'b0, ra, alu_ref(op[2:0], a, op[3] ? sval : b));
        T_INT:
        begin
          m_int_n++;
          push_event(1'b0, ra, int_ref(op[2:0], a, b));
        end
        T_LDI:    push_event(1'b0, ra, ir[IR_SIZE_BIT] ? ext : {17'h0, ir[15:1]});
        T_JUMP:   push_event(1'b1, '0, ir[IR_SIZE_BIT] ? ext : a + soff);
        T_BRANCH:
        begin
          if (branch_taken(op))
            push_event(1'b1, '0, pc + soff);
        end
        T_CMP:
        begin
          m_ltu = (a < b);
          m_lt  = ($signed(a) < $signed(b));
          m_eq  = (a == b);
        end
        default:
          m_halted = m_halted || (op == OP_HALT);
      endcase
    end
  endtask

  task automatic issue_instr(input logic [IR_W-1:0] ir, input int bubbles);
    logic accepted;
    for (int i = 0; i < bubbles; i++)
    begin
      issue_i <= 1'b0;
      @(posedge clk_i);
    end
    issue_i  <= 1'b1;
    ir_i     <= ir;
    pc_i     <= next_pc;
    accepted = 1'b0;
    while (!accepted)
    begin
      @(negedge clk_i);
      accepted = !stall_o;
      @(posedge clk_i);
    end
    model_exec(ir, next_pc);
    next_pc = next_pc + 32'd4;
  endtask

  task automatic check_wb(input logic [REG_AW-1:0] exp_reg, got_reg,
                          input logic [DATA_W-1:0] exp_data, got_data);
    if (got_reg !== exp_reg)
    begin
      $display("ERR wb_reg_o got %h expected %h", got_reg, exp_reg);
      wb_err++;
    end
    if (got_data !== exp_data)
    begin
      $display("ERR wb_data_o got %h expected %h", got_data, exp_data);
      wb_err++;
    end
  endtask

  task automatic check_branch(input logic [DATA_W-1:0] exp_pc, got_pc);
    if (got_pc !== exp_pc)
    begin
      $display("ERR pc_o got %h expected %h", got_pc, exp_pc);
      br_err++;
    end
  endtask

  task automatic check_ccr(input logic [2:0] exp_ccr, got_ccr);
    if (got_ccr !== exp_ccr)
    begin
      $display("ERR ccr_o got %h expected %h", got_ccr, exp_ccr);
      end_err++;
    end
  endtask

  task automatic take_event(input bit is_br, input logic [REG_AW-1:0] got_reg,
                            input logic [DATA_W-1:0] got_val);
    if (ev_seen >= ev_val_q.size())
    begin
      $display("a %s appeared when the model expects no more events",
               is_br ? "branch" : "writeback");
      seq_err++;
    end
    else if (ev_br_q[ev_seen] != is_br)
    begin
      $display("event %0d is of the wrong kind, a %s was not expected here",
               ev_seen, is_br ? "branch" : "writeback");
      seq_err++;
    end
    else if (is_br)
      check_branch(ev_val_q[ev_seen], got_val);
    else
      check_wb(ev_reg_q[ev_seen], got_reg, ev_val_q[ev_seen], got_val);
    ev_seen++;
  endtask

  always @(negedge clk_i)
  begin
    if (!rst_i)
    begin
      if (wb_valid_o)
        take_event(1'b0, wb_reg_o, wb_data_o);
      if (pc_set_o)
        take_event(1'b1, '0, pc_o);
      if (stall_o)
        stall_run = stall_run + 1;
      else if (stall_run != 0)
      begin
        if (stall_run != INT_DELAY)
        begin
          $display("stall_o was high for %0d cycles instead of %0d", stall_run, INT_DELAY);
          seq_err++;
        end
        stall_runs++;
        stall_run = 0;
      end
    end
  end

  initial
  begin
    logic [IR_W-1:0] ir;
    int              gaps;
    int              total;
    rst_i    = 1'b1;
    issue_i  = 1'b0;
    ir_i     = '0;
    pc_i     = '0;
    lfsr_q   = 32'hf964_3b2b;
    next_pc  = 32'h0000_1000;
    m_ltu    = 1'b0;
    m_lt     = 1'b0;
    m_eq     = 1'b0;
    m_halted = 1'b0;
    for (int i = 0; i < REG_N; i++)
      m_regs[i] = '0;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    if ({stall_o, wb_valid_o, pc_set_o, halt_o, ccr_o} !== '0)
    begin
      $display("outputs are not inactive after reset");
      end_err++;
    end
    @(posedge clk_i);
    for (int n = 0; n < N_INSTR; n++)
    begin
      ir   = make_instr();
      gaps = pick_bubbles();
      issue_instr(ir, gaps);
    end
    issue_instr(HALT_IR, 0);
    for (int n = 0; n < N_AFTER; n++)
    begin
      ir = make_instr();
      issue_instr(ir, 0);
    end
    issue_i <= 1'b0;
    repeat (20) @(posedge clk_i);
    @(negedge clk_i);
    if (halt_o !== 1'b1)
    begin
      $display("halt_o is not high after the halt instruction");
      end_err++;
    end
    if (ev_seen != ev_val_q.size())
    begin
      $display("saw %0d events but the model expects %0d", ev_seen, ev_val_q.size());
      end_err++;
    end
    if (stall_runs != m_int_n)
    begin
      $display("stall_o rose %0d times for %0d multiply or divide instructions",
               stall_runs, m_int_n);
      seq_err++;
    end
    check_ccr({m_ltu, m_lt, m_eq}, ccr_o);
    total = wb_err + br_err + seq_err + end_err;
    $display("error counts: writeback %0d, branch %0d, sequence %0d, other %0d",
             wb_err, br_err, seq_err, end_err);
    if (total == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

/* sim.f */
hw/cpu_pkg.sv
hw/alu_comb.sv
hw/int_calc.sv
hw/reg_file.sv
hw/operand_read.sv
hw/execute.sv
hw/exec_top.sv
test/exec_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module exec_tb -o Vexec_tb || exit 1
out=$(./obj_dir/Vexec_tb) ; echo "$out"
echo "$out" | grep -qx "Done: no errors" && exit 0 || exit 1
